//--- apb_pkg.sv
package apb_pkg;

  // the address counts words and not bytes, so one step of paddr is one 32-bit word
  localparam int ADDR_W = 12;
  localparam int DATA_W = 32;                   // fixed by the APB4 bus
  localparam int STRB_W = DATA_W / 8;           // one strobe bit per byte lane

  // fields the master drives during setup and holds through the access phase
  typedef struct packed {
    logic [ADDR_W-1:0] paddr;                   // word index into the memory
    logic              pwrite;                  // high for a write, low for a read
    logic [DATA_W-1:0] pwdata;                  // write data, ignored on reads
    logic [STRB_W-1:0] pstrb;                   // byte lanes to update on a write
  } apb_req_t;

  // what the slave returns while pready is high
  typedef struct packed {
    logic [DATA_W-1:0] prdata;                  // read data, zero for writes and errors
    logic              pslverr;                 // address beyond the memory depth
  } apb_rsp_t;

endpackage

//--- mem_pkg.sv
package mem_pkg;

  import apb_pkg::*;                            // the memory side reuses the bus widths

  // only two operations reach the bank
  typedef enum logic {
    MEM_READ  = 1'b0,
    MEM_WRITE = 1'b1
  } mem_op_e;

  // one memory request, built from the APB request at setup time
  typedef struct packed {
    mem_op_e           op;
    logic [ADDR_W-1:0] addr;                    // still the full bus address, range check is in the bank
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
  } mem_req_t;

  // response from the bank, one per request
  typedef struct packed {
    logic [DATA_W-1:0] rdata;
    logic              err;                     // set when the address is out of range
  } mem_rsp_t;

endpackage

//--- wait_timer.sv
`timescale 1ns/1ps

module wait_timer #(
  parameter int WAIT_STATES = 2
) (
  input  logic pclk,
  input  logic rst_n_i,
  input  logic start_i,
  output logic done_o
);

  // at least one bit, even when no wait states are configured
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  logic [CNT_W-1:0] cnt_q;                      // access cycles still to wait

  // start reloads the count and it then counts down to zero and stays there
  // until the next transfer starts it again
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      cnt_q <= '0;                              // idle timer reads as done
    end else if (start_i) begin
      cnt_q <= CNT_W'(WAIT_STATES);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // with WAIT_STATES at 0 the load leaves the count at zero, so done never drops
  assign done_o = (cnt_q == '0);

endmodule

//--- pipe_slice.sv
`timescale 1ns/1ps

module pipe_slice #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     pclk,
  input  logic     rst_n_i,
  input  logic     in_valid_i,
  output logic     in_ready_o,
  input  payload_t in_data_i,
  output logic     out_valid_o,
  input  logic     out_ready_i,
  output payload_t out_data_o
);

  logic     valid_q;                            // the entry holds an item
  payload_t data_q;                             // the item itself
  logic     load;                               // an item is accepted on this edge

  // ready while empty, or while the held item leaves on the same edge,
  // which gives one item per cycle when the consumer keeps draining
  assign in_ready_o = !valid_q || out_ready_i;
  assign load       = in_valid_i && in_ready_o;

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;                    // refill or go empty
    end
  end

  // the payload only moves when a new item is taken
  always_ff @(posedge pclk) begin
    if (load) begin
      data_q <= in_data_i;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

endmodule

//--- sram_bank.sv
`timescale 1ns/1ps

module sram_bank import apb_pkg::*, mem_pkg::*; #(
  parameter int MEM_DEPTH = 256
) (
  input  logic     pclk,
  input  logic     rst_n_i,
  input  logic     req_valid_i,
  output logic     req_ready_o,
  input  mem_req_t req_i,
  output logic     rsp_valid_o,
  input  logic     rsp_ready_i,
  output mem_rsp_t rsp_o
);

  localparam int IDX_W = (MEM_DEPTH > 1) ? $clog2(MEM_DEPTH) : 1;

  logic [DATA_W-1:0] mem_q [MEM_DEPTH];
  logic [IDX_W-1:0]  idx;                       // word index once the range check passed
  logic              in_range;
  logic              accept;                    // request taken on this edge
  logic              rsp_valid_q;
  mem_rsp_t          rsp_q;

  assign in_range = int'(req_i.addr) < MEM_DEPTH;
  assign idx      = req_i.addr[IDX_W-1:0];

  // a held response blocks new requests until it is taken
  assign req_ready_o = !rsp_valid_q || rsp_ready_i;
  assign accept      = req_valid_i && req_ready_o;

  // after reset every word holds its own index
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MEM_DEPTH; i++) mem_q[i] <= DATA_W'(i);
    end else if (accept && in_range && req_i.op == MEM_WRITE) begin
      for (int b = 0; b < STRB_W; b++) begin
        if (req_i.strb[b]) mem_q[idx][8*b +: 8] <= req_i.wdata[8*b +: 8]; // only selected lanes
      end
    end
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      rsp_valid_q <= 1'b0;
    end else if (accept) begin
      rsp_valid_q <= 1'b1;                      // answer one cycle after the request
    end else if (rsp_ready_i) begin
      rsp_valid_q <= 1'b0;
    end
  end

  // writes and out-of-range accesses return zero data
  always_ff @(posedge pclk) begin
    if (accept) begin
      rsp_q.err   <= !in_range;
      rsp_q.rdata <= (in_range && req_i.op == MEM_READ) ? mem_q[idx] : '0;
    end
  end

  assign rsp_valid_o = rsp_valid_q;
  assign rsp_o       = rsp_q;

endmodule

//--- apb_ctrl_fsm.sv
`timescale 1ns/1ps

module apb_ctrl_fsm import apb_pkg::*, mem_pkg::*; #(
  parameter int WAIT_STATES = 2
) (
  input  logic     pclk,
  input  logic     rst_n_i,
  input  logic     psel_i,
  input  logic     penable_i,
  input  apb_req_t apb_req_i,
  output logic     req_valid_o,
  output mem_req_t req_o,
  input  logic     req_ready_i,
  input  logic     rsp_valid_i,
  input  mem_rsp_t rsp_i,
  output logic     rsp_ready_o,
  output logic     timer_start_o,
  input  logic     timer_done_i,
  output logic     pready_o,
  output apb_rsp_t apb_rsp_o
);

  // IDLE waits for a setup phase, ISSUE covers a request slice that is not ready yet,
  // WAIT_RSP waits for the bank answer and the timer, DONE is the pready cycle
  typedef enum logic [1:0] {
    IDLE,
    ISSUE,
    WAIT_RSP,
    DONE
  } state_e;

  state_e   state_q;
  state_e   state_d;
  apb_rsp_t rsp_q;                              // response shown on the bus during pready
  logic     setup;                              // psel high with penable low
  logic     rsp_take;                           // response and timer both present

  assign setup = psel_i && !penable_i;

  // the timer already reads as done when no wait states are configured
  assign rsp_take = (state_q == WAIT_RSP) && rsp_valid_i && timer_done_i;

  // the master holds all request fields stable until pready, so the request is
  // mapped straight from the bus and stays valid for as long as ISSUE lasts
  assign req_o = '{
    op:    (apb_req_i.pwrite ? MEM_WRITE : MEM_READ),
    addr:  apb_req_i.paddr,
    wdata: apb_req_i.pwdata,
    strb:  apb_req_i.pstrb
  };

  always_comb begin
    state_d       = state_q;
    req_valid_o   = 1'b0;
    timer_start_o = 1'b0;
    rsp_ready_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (setup) begin
          req_valid_o   = 1'b1;                 // request goes out in the setup cycle itself
          timer_start_o = 1'b1;                 // wait states count from the first access cycle
          state_d       = req_ready_i ? WAIT_RSP : ISSUE;
        end
      end
      ISSUE: begin
        req_valid_o = 1'b1;                     // keep offering until the slice takes it
        if (req_ready_i) state_d = WAIT_RSP;
      end
      WAIT_RSP: begin
        if (rsp_take) state_d = DONE;
      end
      DONE: begin
        rsp_ready_o = 1'b1;                     // the response is popped only in the pready cycle
        state_d     = IDLE;
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // prdata is zero out of reset, then it keeps the last completed response
  always_ff @(posedge pclk) begin
    if (!rst_n_i) begin
      rsp_q <= '0;
    end else if (rsp_take) begin
      rsp_q.prdata  <= rsp_i.rdata;
      rsp_q.pslverr <= rsp_i.err;
    end
  end

  assign pready_o  = (state_q == DONE);         // comes from a register, so it is low after reset
  assign apb_rsp_o = rsp_q;

endmodule

//--- apb_mem_top.sv
`timescale 1ns/1ps

module apb_mem_top import apb_pkg::*, mem_pkg::*; #(
  parameter int MEM_DEPTH   = 256,
  parameter int WAIT_STATES = 2
) (
  input  logic     pclk,
  input  logic     rst_n_i,
  input  logic     psel_i,
  input  logic     penable_i,
  input  apb_req_t apb_req_i,
  output logic     pready_o,
  output apb_rsp_t apb_rsp_o
);

  // request path, state machine to slice to bank
  logic     req_valid;
  mem_req_t req;
  logic     req_ready;
  logic     mem_valid;
  mem_req_t mem_req;
  logic     mem_ready;

  // response path, bank to slice to state machine
  logic     rsp_valid;
  mem_rsp_t rsp;
  logic     rsp_ready;
  logic     slice_rsp_valid;
  mem_rsp_t slice_rsp;
  logic     slice_rsp_ready;

  logic     start;                              // timer load at setup
  logic     done;                               // wait states elapsed

  apb_ctrl_fsm #(
    .WAIT_STATES (WAIT_STATES)
  ) i_apb_ctrl_fsm (
    .pclk          (pclk),
    .rst_n_i       (rst_n_i),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .apb_req_i     (apb_req_i),
    .req_valid_o   (req_valid),
    .req_o         (req),
    .req_ready_i   (req_ready),
    .rsp_valid_i   (slice_rsp_valid),
    .rsp_i         (slice_rsp),
    .rsp_ready_o   (slice_rsp_ready),
    .timer_start_o (start),
    .timer_done_i  (done),
    .pready_o      (pready_o),
    .apb_rsp_o     (apb_rsp_o)
  );

  wait_timer #(
    .WAIT_STATES (WAIT_STATES)
  ) i_wait_timer (
    .pclk    (pclk),
    .rst_n_i (rst_n_i),
    .start_i (start),
    .done_o  (done)
  );

  pipe_slice #(
    .payload_t (mem_req_t)
  ) req_slice (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (req_valid),
    .in_ready_o  (req_ready),
    .in_data_i   (req),
    .out_valid_o (mem_valid),
    .out_ready_i (mem_ready),
    .out_data_o  (mem_req)
  );

  sram_bank #(
    .MEM_DEPTH (MEM_DEPTH)
  ) i_sram_bank (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .req_valid_i (mem_valid),
    .req_ready_o (mem_ready),
    .req_i       (mem_req),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_o       (rsp)
  );

  pipe_slice #(
    .payload_t (mem_rsp_t)
  ) rsp_slice (
    .pclk        (pclk),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (rsp_valid),
    .in_ready_o  (rsp_ready),
    .in_data_i   (rsp),
    .out_valid_o (slice_rsp_valid),
    .out_ready_i (slice_rsp_ready),
    .out_data_o  (slice_rsp)
  );

endmodule

//--- apb_mem_sva.sv
`timescale 1ns/1ps

module apb_mem_sva import mem_pkg::*; (
  input logic     pclk,
  input logic     rst_n_i,
  input logic     psel_i,
  input logic     penable_i,
  input logic     pready_i,
  input logic     mem_valid_i,                  // request slice output
  input logic     mem_ready_i,
  input mem_req_t mem_req_i,
  input logic     slice_valid_i,                // response slice output
  input logic     slice_ready_i,
  input mem_rsp_t slice_rsp_i
);

  // pready may only rise while the master is in its access phase
  a_pready_access: assert property (@(posedge pclk) disable iff (!rst_n_i)
    pready_i |-> (psel_i && penable_i))
    else $error("pready high outside the access phase");

  a_pready_reset: assert property (@(posedge pclk) !rst_n_i |=> !pready_i)
    else $error("pready high in the cycle after reset");

  // a slice keeps its item and its valid until the consumer takes it
  a_req_hold: assert property (@(posedge pclk) disable iff (!rst_n_i)
    (mem_valid_i && !mem_ready_i) |=> (mem_valid_i && $stable(mem_req_i)))
    else $error("request slice dropped or changed an item before it was accepted");

  a_rsp_hold: assert property (@(posedge pclk) disable iff (!rst_n_i)
    (slice_valid_i && !slice_ready_i) |=> (slice_valid_i && $stable(slice_rsp_i)))
    else $error("response slice dropped or changed an item before it was accepted");

endmodule

bind apb_mem_top apb_mem_sva i_apb_mem_sva (
  .pclk          (pclk),
  .rst_n_i       (rst_n_i),
  .psel_i        (psel_i),
  .penable_i     (penable_i),
  .pready_i      (pready_o),
  .mem_valid_i   (mem_valid),
  .mem_ready_i   (mem_ready),
  .mem_req_i     (mem_req),
  .slice_valid_i (slice_rsp_valid),
  .slice_ready_i (slice_rsp_ready),
  .slice_rsp_i   (slice_rsp)
);

//--- tb_apb_mem.sv
`timescale 1ns/1ps

module tb_apb_mem import apb_pkg::*; ();

  localparam int MEM_DEPTH   = 256;
  localparam int WAIT_STATES = 2;
  localparam int MAX_VEC     = 64;              // room for every line of the golden file

  logic     pclk;
  logic     rst_n;
  logic     psel;
  logic     penable;
  apb_req_t apb_req;
  logic     pready;
  apb_rsp_t apb_rsp;

  // one entry per golden line
  logic [95:0]       vec_name  [MAX_VEC];       // test name, up to 12 characters
  logic [7:0]        vec_op    [MAX_VEC];       // "r" or "w"
  logic [ADDR_W-1:0] vec_addr  [MAX_VEC];
  logic [DATA_W-1:0] vec_wdata [MAX_VEC];
  logic [STRB_W-1:0] vec_strb  [MAX_VEC];
  logic [DATA_W-1:0] vec_rdata [MAX_VEC];       // expected prdata
  logic              vec_err   [MAX_VEC];       // expected pslverr
  int n_vec       = 0;
  int cycle_cnt   = 0;
  int cycle_limit = 0;                          // zero until the golden file is read
  int n_checks    = 0;
  int n_mismatch  = 0;
  int n_other     = 0;

  apb_mem_top #(
    .MEM_DEPTH   (MEM_DEPTH),
    .WAIT_STATES (WAIT_STATES)
  ) i_apb_mem_top (
    .pclk      (pclk),
    .rst_n_i   (rst_n),
    .psel_i    (psel),
    .penable_i (penable),
    .apb_req_i (apb_req),
    .pready_o  (pready),
    .apb_rsp_o (apb_rsp)
  );

  initial begin
    pclk = 1'b0;
    forever #2 pclk = ~pclk;                    // 4 ns period
  end

  // ends a run that stops making progress
  always @(posedge pclk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
      $display("error: run timed out after %0d cycles", cycle_cnt);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // skips comment and blank lines and keeps the rest
  task automatic load_vectors();
    int                fd;
    int                cnt;
    string             line;
    logic [95:0]       name;
    logic [7:0]        op;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] wdata;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] rdata;
    logic              err;
    fd = $fopen("apb_mem_golden.txt", "r");
    if (fd == 0) begin
      $display("error: cannot open apb_mem_golden.txt");
      n_other++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() < 2 || line[0] == "#") continue;
      cnt = $sscanf(line, "%s %s %h %h %h %h %h", name, op, addr, wdata, strb, rdata, err);
      if (cnt != 7 || n_vec == MAX_VEC) begin
        $display("error: golden line not usable: %s", line);
        n_other++;
      end else begin
        vec_name[n_vec]  = name;
        vec_op[n_vec]    = op;
        vec_addr[n_vec]  = addr;
        vec_wdata[n_vec] = wdata;
        vec_strb[n_vec]  = strb;
        vec_rdata[n_vec] = rdata;
        vec_err[n_vec]   = err;
        n_vec++;
      end
    end
    $fclose(fd);
    if (n_vec == 0) begin
      $display("error: golden file holds no transfers");
      n_other++;
    end
  endtask

  // setup on one falling edge, access from the next, pready looked at mid-cycle
  task automatic run_transfer(input int k, output logic [DATA_W-1:0] rdata,
                              output logic err, output int waits);
    int access;
    @(negedge pclk);
    psel           = 1'b1;
    penable        = 1'b0;
    apb_req.paddr  = vec_addr[k];
    apb_req.pwrite = (vec_op[k] == "w");
    apb_req.pwdata = vec_wdata[k];
    apb_req.pstrb  = vec_strb[k];
    @(negedge pclk);
    penable = 1'b1;
    access  = 1;
    while (pready !== 1'b1) begin               // a stuck slave is caught by the cycle counter
      @(negedge pclk);
      access++;
    end
    rdata = apb_rsp.prdata;
    err   = apb_rsp.pslverr;
    waits = access - 1;                         // access cycles with pready still low
  endtask

  task automatic idle_bus(input int n);
    repeat (n) begin
      @(negedge pclk);
      psel    = 1'b0;
      penable = 1'b0;
    end
  endtask

  initial begin
    logic [DATA_W-1:0] rdata;
    logic              err;
    int                waits;
    int                gap;
    void'($urandom(60758));
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    apb_req = '0;
    load_vectors();
    cycle_limit = 40 * n_vec + 100;
    repeat (2) @(posedge pclk);                 // two cycles of reset
    @(negedge pclk);
    rst_n = 1'b1;
    n_checks += 2;
    if (pready !== 1'b0) begin
      n_mismatch++;
      $display("mismatch reset pready: expected 0, actual %b", pready);
    end
    if (apb_rsp.prdata !== '0) begin
      n_mismatch++;
      $display("mismatch reset prdata: expected 00000000, actual %h", apb_rsp.prdata);
    end
    if (n_other == 0) begin
      for (int k = 0; k < n_vec; k++) begin
        gap = $urandom % 4;                     // 0 to 3 idle cycles before each transfer
        idle_bus(gap);
        run_transfer(k, rdata, err, waits);
        n_checks += 3;
        if (err !== vec_err[k]) begin
          n_mismatch++;
          $display("mismatch %0s pslverr: expected %b, actual %b", vec_name[k], vec_err[k], err);
        end
        if (rdata !== vec_rdata[k]) begin
          n_mismatch++;
          $display("mismatch %0s prdata: expected %h, actual %h", vec_name[k], vec_rdata[k],
                   rdata);
        end
        if (waits < WAIT_STATES) begin
          n_other++;
          $display("error: %0s got pready after only %0d access cycles, fewer than %0d",
                   vec_name[k], waits, WAIT_STATES);
        end
      end
    end
    idle_bus(3);
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- apb_mem_golden.txt
# name op addr wdata strb exp_prdata exp_pslverr
# op is r for a read and w for a write, every other column except the name is hex
rst_rd_000 r 000 00000000 0 00000000 0
rst_rd_001 r 001 00000000 0 00000001 0
rst_rd_07f r 07f 00000000 0 0000007f 0
rst_rd_0ff r 0ff 00000000 0 000000ff 0
full_wr_010 w 010 deadbeef f 00000000 0
full_rd_010 r 010 00000000 0 deadbeef 0
full_wr_0ff w 0ff 12345678 f 00000000 0
full_rd_0ff r 0ff 00000000 0 12345678 0
part_wr_020 w 020 aabbccdd 3 00000000 0
part_rd_020 r 020 00000000 0 0000ccdd 0
part_wr_021 w 021 11223344 c 00000000 0
part_rd_021 r 021 00000000 0 11220021 0
part_wr_022 w 022 55667788 5 00000000 0
part_rd_022 r 022 00000000 0 00660088 0
part_wr_023 w 023 ffffffff 0 00000000 0
part_rd_023 r 023 00000000 0 00000023 0
err_wr_130 w 130 cafef00d f 00000000 1
err_rd_030 r 030 00000000 0 00000030 0
err_rd_100 r 100 00000000 0 00000000 1
err_rd_fff r fff 00000000 0 00000000 1
err_wr_1ff w 1ff 0badf00d f 00000000 1
err_rd_0ff r 0ff 00000000 0 12345678 0
b2b_wr_000 w 000 a5a5a5a5 f 00000000 0
b2b_rd_000 r 000 00000000 0 a5a5a5a5 0
b2b_rd_010 r 010 00000000 0 deadbeef 0

//--- files.f
apb_pkg.sv
mem_pkg.sv
wait_timer.sv
pipe_slice.sv
sram_bank.sv
apb_ctrl_fsm.sv
apb_mem_top.sv
apb_mem_sva.sv
tb_apb_mem.sv

//--- run.sh
#!/usr/bin/env bash
# builds the testbench with verilator, runs it from the project root and checks the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_apb_mem -f files.f -o sim_apb_mem
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_apb_mem > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" sim.log; then
  exit 0
fi
echo "pass line not found in sim.log"
exit 1
